// ==== list.f ====
rtl/cache_biu_pkg.sv
rtl/biu_fsm.sv
rtl/burst_tracker.sv
rtl/line_buffer.sv
rtl/bus_request_mux.sv
rtl/cache_biu_top.sv
verif/bus_slave_model.sv
verif/tb_cache_biu.sv

// ==== rtl/biu_fsm.sv ====
module biu_fsm
  import cache_biu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  input  biucmd_t    cmd_i,
  input  logic       stb_ack_i,
  input  logic       ack_i,
  input  logic       err_i,
  input  logic       last_beat_i,  // beat countdown at zero

  output biu_state_e state_o,
  output logic       busy_o,
  output logic       cmd_ack_o
);

  biu_state_e state_q;
  logic       burst_done;

  // last beat acknowledged, or slave gave up
  assign burst_done = err_i | (ack_i & last_beat_i);

  //////////////////////////////////////////////////
  // sequencer

  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
    begin
      state_q <= ST_IDLE;
      busy_o  <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
          if (cmd_i != BIUCMD_NOP)
          begin
            busy_o  <= 1'b1;
            state_q <= stb_ack_i ? ST_BURST : ST_WAIT4BIU; // stretch if not taken
          end

        ST_WAIT4BIU:
          if (stb_ack_i)
          begin
            state_q <= ST_BURST;
          end

        ST_BURST:
          if (burst_done)
          begin
            state_q <= ST_IDLE; // always one idle cycle between bursts
            busy_o  <= 1'b0;
          end

        default: state_q <= ST_IDLE;
      endcase
    end

  assign state_o   = state_q;
  assign cmd_ack_o = (state_q == ST_BURST) & burst_done; // same cycle as final ack

endmodule

// ==== rtl/burst_tracker.sv ====
module burst_tracker
  import cache_biu_pkg::*;
#(
  parameter int XLEN           = 32,
  parameter int LINE_BITS      = 128,
  parameter int INFLIGHT_DEPTH = 2,

  localparam int INFLIGHT_BITS = inflight_bits(INFLIGHT_DEPTH, XLEN, LINE_BITS)
)
(
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  biu_state_e               state_i,
  input  logic                     stb_ack_i,
  input  logic                     ack_i,
  input  logic                     err_i,
  input  biu_type_t                type_i,
  input  logic                     flush_i,

  output logic                     last_beat_o,
  output logic [INFLIGHT_BITS-1:0] inflight_cnt_o,
  output logic                     noncacheable_ack_o
);

  localparam int BURST_WORDS = burst_words(XLEN, LINE_BITS);
  localparam int BURST_BITS  = $clog2(BURST_WORDS);

  logic [BURST_BITS   -1:0] beat_cnt_q;
  logic [INFLIGHT_BITS-1:0] discard_q;
  logic [INFLIGHT_BITS-1:0] burst_len;
  logic                     beat_done;

  assign beat_done = ack_i | err_i;                                  // a beat leaves the bus
  assign burst_len = INFLIGHT_BITS'(burst_type_beats(type_i)) + 1'b1;

  //////////////////////////////////////////////////
  // line beat countdown

  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
    begin
      beat_cnt_q <= '1;
    end
    else if (state_i == ST_IDLE)
    begin
      beat_cnt_q <= '1;                   // words per line minus one
    end
    else if (state_i == ST_BURST && ack_i)
    begin
      beat_cnt_q <= beat_cnt_q - 1'b1;
    end

  assign last_beat_o = ~|beat_cnt_q;

  //////////////////////////////////////////////////
  // outstanding beats

  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
    begin
      inflight_cnt_o <= '0;
    end
    else
    begin
      case ({stb_ack_i, beat_done})
        2'b01   : inflight_cnt_o <= inflight_cnt_o - 1'b1;
        2'b10   : inflight_cnt_o <= inflight_cnt_o + burst_len;
        2'b11   : inflight_cnt_o <= inflight_cnt_o + burst_len - 1'b1; // new in, one out
        default : ;
      endcase
    end

  // acks still owed to flushed accesses
  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
    begin
      discard_q <= '0;
    end
    else if (flush_i)
    begin
      if (|inflight_cnt_o && beat_done)
        discard_q <= inflight_cnt_o - 1'b1; // one retires in the flush cycle
      else
        discard_q <= inflight_cnt_o;
    end
    else if (|discard_q && beat_done)
    begin
      discard_q <= discard_q - 1'b1;
    end

  assign noncacheable_ack_o = ack_i & ~flush_i & ~|discard_q;

endmodule

// ==== rtl/bus_request_mux.sv ====
module bus_request_mux
  import cache_biu_pkg::*;
#(
  parameter int XLEN      = 32,
  parameter int PLEN      = 32,
  parameter int LINE_BITS = 128
)
(
  input  logic                 clk_i,

  input  biu_state_e           state_i,
  input  biucmd_t              cmd_i,
  input  logic                 noncacheable_req_i,
  input  logic [PLEN     -1:0] adr_i,
  input  logic                 we_i,
  input  logic [XLEN     -1:0] d_i,
  input  logic [PLEN     -1:0] evict_adr_i,
  input  logic [LINE_BITS-1:0] evict_line_i,
  input  logic [XLEN     -1:0] wdata_i,       // shifted write-back word

  output logic                 stb_o,
  output logic [PLEN     -1:0] adr_o,
  output logic                 we_o,
  output logic [XLEN     -1:0] d_o,
  output biu_type_t            type_o,
  output biu_prot_t            prot_o,
  output logic [PLEN     -1:0] hold_adr_o
);

  localparam int        BURST_WORDS = burst_words(XLEN, LINE_BITS);
  localparam int        BYTE_LSB    = $clog2(XLEN/8);
  localparam biu_type_t LINE_TYPE   = (BURST_WORDS == 16) ? WRAP16 :
                                      (BURST_WORDS ==  8) ? WRAP8  : WRAP4;

  logic [PLEN-1:0] adr_hold_q;
  logic            we_hold_q;
  logic [XLEN-1:0] d_hold_q;
  logic            pass_through;  // idle with no cache command

  assign pass_through = (state_i == ST_IDLE) && (cmd_i == BIUCMD_NOP);

  //////////////////////////////////////////////////
  // request select

  always_comb
  begin
    stb_o = 1'b0;
    adr_o = '0;
    we_o  = 1'b0;
    d_o   = '0;
    case (state_i)
      ST_IDLE:
        case (cmd_i)
          BIUCMD_READWAY:
          begin
            stb_o = 1'b1;
            adr_o = {adr_i[PLEN-1:BYTE_LSB], {BYTE_LSB{1'b0}}}; // critical word first
          end
          BIUCMD_WRITEWAY:
          begin
            stb_o = 1'b1;
            adr_o = evict_adr_i;
            we_o  = 1'b1;
            d_o   = evict_line_i[XLEN-1:0];
          end
          default:
          begin
            stb_o = noncacheable_req_i;
            adr_o = adr_i;
            we_o  = we_i;
            d_o   = d_i;
          end
        endcase

      ST_WAIT4BIU:
      begin
        stb_o = 1'b1;        // keep asking until stb_ack
        adr_o = adr_hold_q;
        we_o  = we_hold_q;
        d_o   = d_hold_q;
      end

      ST_BURST: d_o = wdata_i; // no new strobe mid-burst

      default: ;
    endcase
  end

  // snapshot of the last idle request, replayed while stretched
  always_ff @(posedge clk_i)
    if (state_i == ST_IDLE)
    begin
      adr_hold_q <= adr_o;
      we_hold_q  <= we_o;
      d_hold_q   <= d_o;
    end

  assign hold_adr_o = adr_hold_q;

  // misaligned single access cannot be part of an incrementing run
  assign type_o = pass_through ? (|adr_i[BYTE_LSB-1:0] ? SINGLE : INCR) : LINE_TYPE;
  assign prot_o = pass_through ? PROT_NONCACHEABLE : PROT_CACHEABLE;

endmodule

// ==== rtl/cache_biu_pkg.sv ====
package cache_biu_pkg;

  //////////////////////////////////////////////////
  // command, burst and protection encodings

  // commands from the cache controller
  typedef enum logic [1:0] {
    BIUCMD_NOP,      // idle, non-cacheable traffic may pass
    BIUCMD_READWAY,  // line fill
    BIUCMD_WRITEWAY  // line write-back
  } biucmd_t;

  typedef enum logic [2:0] {
    SINGLE,
    INCR,
    WRAP4,
    WRAP8,
    WRAP16
  } biu_type_t;

  typedef logic [2:0] biu_prot_t;

  localparam biu_prot_t PROT_NONCACHEABLE = 3'b000;
  localparam biu_prot_t PROT_CACHEABLE    = 3'b100; // bit 2 flags cacheable

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT4BIU,  // strobe stretched, no stb_ack yet
    ST_BURST
  } biu_state_e;

  //////////////////////////////////////////////////
  // line geometry

  // bus words per cache line
  function automatic int unsigned burst_words(int unsigned xlen, int unsigned line_bits);
    return line_bits / xlen;
  endfunction

  // beats minus one for a burst type
  function automatic logic [3:0] burst_type_beats(biu_type_t btype);
    case (btype)
      WRAP4   : return 4'd3;
      WRAP8   : return 4'd7;
      WRAP16  : return 4'd15;
      default : return 4'd0; // single and incr count one beat
    endcase
  endfunction

  // in-flight counter must hold a full line burst or the pipeline depth
  function automatic int unsigned inflight_bits(int unsigned depth, int unsigned xlen,
                                                int unsigned line_bits);
    int unsigned words;
    int unsigned most;
    words = burst_words(xlen, line_bits);
    most  = (depth > words) ? depth : words;
    return $clog2(most + 1);
  endfunction

endpackage

// ==== rtl/cache_biu_top.sv ====
module cache_biu_top
  import cache_biu_pkg::*;
#(
  parameter int XLEN           = 32,
  parameter int PLEN           = 32,
  parameter int LINE_BITS      = 128,
  parameter int INFLIGHT_DEPTH = 2,

  localparam int INFLIGHT_BITS = inflight_bits(INFLIGHT_DEPTH, XLEN, LINE_BITS)
)
(
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // cache controller side
  input  biucmd_t                  cmd_i,
  output logic                     cmd_ack_o,
  output logic                     busy_o,
  input  logic                     noncacheable_req_i,
  output logic                     noncacheable_ack_o,
  input  logic                     flush_i,
  output logic [INFLIGHT_BITS-1:0] inflight_cnt_o,

  input  logic [PLEN         -1:0] adr_i,
  input  logic                     we_i,
  input  logic [XLEN/8       -1:0] be_i,
  input  logic [XLEN         -1:0] d_i,
  input  logic [PLEN         -1:0] evict_adr_i,
  input  logic [LINE_BITS    -1:0] evict_line_i,
  output logic                     in_linebuf_o,
  output logic [LINE_BITS    -1:0] line_o,       // fill data for the data memory
  output logic                     line_dirty_o,

  // memory bus side
  output logic                     stb_o,
  input  logic                     stb_ack_i,
  input  logic                     d_ack_i,      // slave wants next write word
  output logic [PLEN         -1:0] adr_o,
  input  logic [PLEN         -1:0] adro_i,
  output logic                     we_o,
  output logic [XLEN         -1:0] d_o,
  output biu_type_t                type_o,
  output biu_prot_t                prot_o,
  input  logic [XLEN         -1:0] q_i,
  input  logic                     ack_i,
  input  logic                     err_i
);

  biu_state_e      state;
  logic            last_beat;
  logic [PLEN-1:0] hold_adr;
  logic [XLEN-1:0] wdata;

  //////////////////////////////////////////////////
  // control

  biu_fsm u_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (cmd_i),
    .stb_ack_i   (stb_ack_i),
    .ack_i       (ack_i),
    .err_i       (err_i),
    .last_beat_i (last_beat),
    .state_o     (state),
    .busy_o      (busy_o),
    .cmd_ack_o   (cmd_ack_o)
  );

  burst_tracker #(
    .XLEN           (XLEN),
    .LINE_BITS      (LINE_BITS),
    .INFLIGHT_DEPTH (INFLIGHT_DEPTH)
  ) u_tracker (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .state_i            (state),
    .stb_ack_i          (stb_ack_i),
    .ack_i              (ack_i),
    .err_i              (err_i),
    .type_i             (type_o),     // length of the request being acked
    .flush_i            (flush_i),
    .last_beat_o        (last_beat),
    .inflight_cnt_o     (inflight_cnt_o),
    .noncacheable_ack_o (noncacheable_ack_o)
  );

  //////////////////////////////////////////////////
  // data path

  line_buffer #(
    .XLEN      (XLEN),
    .PLEN      (PLEN),
    .LINE_BITS (LINE_BITS)
  ) u_linebuf (
    .clk_i        (clk_i),
    .state_i      (state),
    .cmd_i        (cmd_i),
    .adr_i        (adr_i),
    .hold_adr_i   (hold_adr),
    .we_i         (we_i),
    .be_i         (be_i),
    .d_i          (d_i),
    .adro_i       (adro_i),
    .q_i          (q_i),
    .ack_i        (ack_i),
    .d_ack_i      (d_ack_i),
    .evict_line_i (evict_line_i),
    .line_o       (line_o),
    .line_dirty_o (line_dirty_o),
    .in_linebuf_o (in_linebuf_o),
    .wdata_o      (wdata)
  );

  bus_request_mux #(
    .XLEN      (XLEN),
    .PLEN      (PLEN),
    .LINE_BITS (LINE_BITS)
  ) u_reqmux (
    .clk_i              (clk_i),
    .state_i            (state),
    .cmd_i              (cmd_i),
    .noncacheable_req_i (noncacheable_req_i),
    .adr_i              (adr_i),
    .we_i               (we_i),
    .d_i                (d_i),
    .evict_adr_i        (evict_adr_i),
    .evict_line_i       (evict_line_i),
    .wdata_i            (wdata),
    .stb_o              (stb_o),
    .adr_o              (adr_o),
    .we_o               (we_o),
    .d_o                (d_o),
    .type_o             (type_o),
    .prot_o             (prot_o),
    .hold_adr_o         (hold_adr)
  );

endmodule

// ==== rtl/line_buffer.sv ====
module line_buffer
  import cache_biu_pkg::*;
#(
  parameter int XLEN      = 32,
  parameter int PLEN      = 32,
  parameter int LINE_BITS = 128
)
(
  input  logic                 clk_i,

  input  biu_state_e           state_i,
  input  biucmd_t              cmd_i,
  input  logic [PLEN     -1:0] adr_i,       // cpu request address
  input  logic [PLEN     -1:0] hold_adr_i,  // start address of the running burst
  input  logic                 we_i,        // pending cpu store
  input  logic [XLEN/8   -1:0] be_i,
  input  logic [XLEN     -1:0] d_i,
  input  logic [PLEN     -1:0] adro_i,      // address of the current beat
  input  logic [XLEN     -1:0] q_i,
  input  logic                 ack_i,
  input  logic                 d_ack_i,
  input  logic [LINE_BITS-1:0] evict_line_i,

  output logic [LINE_BITS-1:0] line_o,
  output logic                 line_dirty_o,
  output logic                 in_linebuf_o,
  output logic [XLEN     -1:0] wdata_o
);

  localparam int BURST_WORDS = burst_words(XLEN, LINE_BITS);
  localparam int OFFS_BITS   = $clog2(BURST_WORDS);
  localparam int BYTE_LSB    = $clog2(XLEN/8);
  localparam int LINE_LSB    = BYTE_LSB + OFFS_BITS;

  logic [LINE_BITS  -1:0] line_q;
  logic [BURST_WORDS-1:0] valid_q;   // one flag per word
  logic                   dirty_q;
  logic                   is_write_q;
  logic [OFFS_BITS  -1:0] beat_slot;
  logic [OFFS_BITS  -1:0] req_slot;
  logic                   store_hit;
  logic [XLEN       -1:0] beat_data;
  logic                   fill_beat;  // read beat on the bus this cycle

  // byte lanes from the store win over memory data
  function automatic logic [XLEN-1:0] be_merge(input logic [XLEN/8-1:0] be,
                                               input logic [XLEN  -1:0] old_w,
                                               input logic [XLEN  -1:0] new_w);
    logic [XLEN-1:0] res;
    for (int i = 0; i < XLEN/8; i++)
      res[i*8 +: 8] = be[i] ? new_w[i*8 +: 8] : old_w[i*8 +: 8];
    return res;
  endfunction

  assign beat_slot = adro_i[BYTE_LSB +: OFFS_BITS];
  assign req_slot  = adr_i [BYTE_LSB +: OFFS_BITS];
  assign store_hit = we_i & (adro_i[PLEN-1:BYTE_LSB] == adr_i[PLEN-1:BYTE_LSB]);
  assign beat_data = store_hit ? be_merge(be_i, q_i, d_i) : q_i;
  assign fill_beat = (state_i == ST_BURST) && !is_write_q && ack_i;

  //////////////////////////////////////////////////
  // fill / write-back storage

  always_ff @(posedge clk_i)
    case (state_i)
      ST_IDLE:
      begin
        is_write_q <= (cmd_i == BIUCMD_WRITEWAY);
        valid_q    <= '0;
        dirty_q    <= 1'b0;
        if (cmd_i == BIUCMD_WRITEWAY)
          line_q <= evict_line_i >> XLEN; // word 0 goes out with the strobe
      end

      ST_BURST:
        if (is_write_q)
        begin
          if (d_ack_i)
            line_q <= line_q >> XLEN;     // next write word to the bottom
        end
        else if (ack_i)
        begin
          line_q[beat_slot*XLEN +: XLEN] <= beat_data;
          valid_q[beat_slot]             <= 1'b1;
          dirty_q                        <= dirty_q | store_hit;
        end

      default: ;                          // hold while strobe is stretched
    endcase

  // current beat is folded in so the line is whole on the last ack
  always_comb
  begin
    line_o = line_q;
    if (fill_beat)
      line_o[beat_slot*XLEN +: XLEN] = beat_data;
  end

  // dirty as soon as the merged beat is on the bus
  assign line_dirty_o = dirty_q | (fill_beat & store_hit);
  assign wdata_o      = line_q[XLEN-1:0];

  // requested word already arrived for this line
  assign in_linebuf_o = (hold_adr_i[PLEN-1:LINE_LSB] == adr_i[PLEN-1:LINE_LSB]) &
                        valid_q[req_slot];

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the cache bus interface testbench with Verilator

verilator --binary --timing --top-module tb_cache_biu -f list.f -o tb_cache_biu
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/tb_cache_biu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0

// ==== verif/bus_slave_model.sv ====
module bus_slave_model
  import cache_biu_pkg::*;
#(
  parameter int DEPTH = 2  // beats accepted before stb_ack is held off
)
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        stb_i,
  input  logic [31:0] adr_i,
  input  logic        we_i,
  input  logic [31:0] d_i,
  input  biu_type_t   type_i,
  output logic        stb_ack_o,
  output logic        d_ack_o,
  output logic [31:0] adro_o,
  output logic [31:0] q_o,
  output logic        ack_o,
  output logic        err_o
);
  timeunit 1ns;
  timeprecision 100ps;

  integer      seed = 32'hb113;
  logic [36:0] pend[$];        // {we, beat index, address}
  logic [36:0] beat;
  logic [1:0]  stb_wait;
  logic [1:0]  ack_wait;
  logic        full_q;
  logic        cur_we;
  logic [3:0]  cur_idx;
  logic [31:0] cur_adr;
  int          n_beats;
  logic [31:0] mask;

  // captured write beats, read back by the testbench
  logic [31:0] wr_data [64];
  logic [31:0] wr_adr  [64];
  int          wr_cnt;

  assign err_o     = 1'b0;  // slave never errors
  assign stb_ack_o = stb_i && (stb_wait == 2'd0) && !full_q;

  always @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      ack_o    <= 1'b0;
      d_ack_o  <= 1'b0;
      adro_o   <= '0;
      q_o      <= '0;
      stb_wait <= '0;
      ack_wait <= '0;
      full_q   <= 1'b0;
      cur_we   <= 1'b0;
      cur_idx  <= '0;
      cur_adr  <= '0;
      wr_cnt   = 0;
      pend.delete();
    end
    else
    begin
      ack_o   <= 1'b0;
      d_ack_o <= 1'b0;
      // later write words sit on d_i during their ack
      if (ack_o && cur_we && cur_idx != 4'd0)
      begin
        wr_data[wr_cnt] = d_i;
        wr_adr[wr_cnt]  = cur_adr;
        wr_cnt++;
      end
      //////////////////////////////////////////////////
      // request accept
      if (stb_ack_o)
      begin
        n_beats = int'(burst_type_beats(type_i)) + 1;
        mask    = 32'(n_beats * 4 - 1);  // wrap boundary
        for (int k = 0; k < n_beats; k++)
          pend.push_back({we_i, 4'(k), (adr_i & ~mask) | ((adr_i + 32'(k * 4)) & mask)});
        if (we_i)
        begin
          wr_data[wr_cnt] = d_i;         // word 0 rides with the strobe
          wr_adr[wr_cnt]  = adr_i;
          wr_cnt++;
        end
        stb_wait <= 2'($random(seed));
      end
      else if (stb_i && stb_wait != 2'd0)
        stb_wait <= stb_wait - 2'd1;
      //////////////////////////////////////////////////
      // beat responses
      if (pend.size() > 0)
      begin
        if (ack_wait == 2'd0)
        begin
          beat = pend.pop_front();
          ack_o    <= 1'b1;
          adro_o   <= beat[31:0];
          q_o      <= beat[31:0] ^ 32'ha5a5_5a5a;
          d_ack_o  <= beat[36] && beat[35:32] != 4'd0;
          cur_we   <= beat[36];
          cur_idx  <= beat[35:32];
          cur_adr  <= beat[31:0];
          ack_wait <= 2'($random(seed));
        end
        else
          ack_wait <= ack_wait - 2'd1;
      end
      full_q <= (pend.size() >= DEPTH);
    end

endmodule

// ==== verif/tb_cache_biu.sv ====
module tb_cache_biu
  import cache_biu_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_BURSTS = 8;
  localparam int LIMIT      = 40 * NUM_BURSTS + 200;  // cycles

  logic         clk_i = 1'b0;
  logic         rst_ni;
  biucmd_t      cmd_i;
  logic         noncacheable_req_i, flush_i, we_i;
  logic [31:0]  adr_i, d_i, evict_adr_i, adro_i, q_i, adr_o, d_o;
  logic [3:0]   be_i;
  logic [127:0] evict_line_i, line_o;
  logic         cmd_ack_o, busy_o, noncacheable_ack_o, in_linebuf_o, line_dirty_o;
  logic [2:0]   inflight_cnt_o;
  logic         stb_o, stb_ack_i, d_ack_i, we_o, ack_i, err_i;
  biu_type_t    type_o;
  biu_prot_t    prot_o;

  int           n_checks = 0;
  int           n_errors = 0;
  int           cycles   = 0;
  logic         busy_exp, prev_stretch, prev_we;
  logic [31:0]  prev_adr, prev_d;
  logic [3:0]   seen;
  int           inf_exp, disc_exp, n_suppressed;

  always #2 clk_i = ~clk_i;

  cache_biu_top dut_i (.*);

  bus_slave_model u_slave (
    .clk_i (clk_i), .rst_ni (rst_ni), .stb_i (stb_o), .adr_i (adr_o), .we_i (we_o),
    .d_i (d_o), .type_i (type_o), .stb_ack_o (stb_ack_i), .d_ack_o (d_ack_i),
    .adro_o (adro_i), .q_o (q_i), .ack_o (ack_i), .err_o (err_i)
  );

  task automatic check(input logic ok, input string msg);
    n_checks++;
    assert (ok)
    else
    begin
      n_errors++;
      $display("ERROR %0t: %s", $time, msg);
    end
  endtask

  // memory pattern with the cpu store folded in
  function automatic logic [127:0] expected_line(input logic [31:0] adr, input logic we,
                                                 input logic [3:0] be, input logic [31:0] d);
    logic [127:0] l;
    logic [31:0]  w;
    for (int j = 0; j < 4; j++)
    begin
      w = ({adr[31:4], 4'h0} + 32'(j * 4)) ^ 32'ha5a5_5a5a;
      for (int b = 0; b < 4; b++)
        if (we && adr[3:2] == 2'(j) && be[b])
          w[b*8 +: 8] = d[b*8 +: 8];
      l[j*32 +: 32] = w;
    end
    return l;
  endfunction

  //////////////////////////////////////////////////
  // checkers, sampled before the edge updates

  always @(posedge clk_i)
    if (!rst_ni)
    begin
      busy_exp = 1'b0;
      prev_stretch = 1'b0;
      seen = '0;
      inf_exp = 0;
      disc_exp = 0;
      n_suppressed = 0;
    end
    else
    begin
      check(busy_o == busy_exp, "busy_o mismatch");
      busy_exp = busy_exp ? !cmd_ack_o : (cmd_i != BIUCMD_NOP);
      if (prev_stretch)           // held request must not move
        check(adr_o == prev_adr && we_o == prev_we && d_o == prev_d, "stretched strobe moved");
      prev_stretch = stb_o && !stb_ack_i;
      prev_adr = adr_o;
      prev_we  = we_o;
      prev_d   = d_o;
      if (cmd_i == BIUCMD_NOP && !busy_o)
      begin
        check(stb_o == noncacheable_req_i, "stb_o does not follow request");
        if (noncacheable_req_i)
        begin
          check(type_o == ((adr_i[1:0] != 2'b00) ? SINGLE : INCR), "wrong pass-through type");
          check(prot_o == PROT_NONCACHEABLE, "prot_o not non-cacheable");
        end
      end
      else if (stb_o && !busy_o)
        check(prot_o == PROT_CACHEABLE && type_o == WRAP4, "line request type or prot");
      // read line and store merge
      if (cmd_ack_o && cmd_i == BIUCMD_READWAY)
      begin
        check(line_o == expected_line(adr_i, we_i, be_i, d_i),
              $sformatf("line_o %h", line_o));
        check(line_dirty_o == we_i, "line_dirty_o mismatch");
      end
      if (busy_o && cmd_i == BIUCMD_READWAY)
      begin
        check(in_linebuf_o == seen[adr_i[3:2]], "in_linebuf_o mismatch");
        if (ack_i)
          seen[adro_i[3:2]] = 1'b1;
      end
      else
        seen = '0;
      // flush discards and in-flight count
      if (ack_i && disc_exp != 0)
        n_suppressed++;
      check(noncacheable_ack_o == (ack_i && !flush_i && disc_exp == 0),
            "noncacheable_ack_o mismatch");
      check(int'(inflight_cnt_o) == inf_exp, "inflight_cnt_o mismatch");
      if (flush_i)
        disc_exp = inf_exp - (ack_i ? 1 : 0);
      else if (disc_exp != 0 && ack_i)
        disc_exp--;
      // a line is four beats, a pass-through access one
      inf_exp = inf_exp + (stb_ack_i ? ((cmd_i == BIUCMD_NOP) ? 1 : 4) : 0)
                - (ack_i ? 1 : 0);
    end

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles >= LIMIT)
    begin
      $display("timeout after %0d cycles, DUT did not finish", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus

  task automatic read_line(input logic [31:0] adr, input logic we, input logic [3:0] be,
                           input logic [31:0] d);
    adr_i <= adr;
    we_i  <= we;
    be_i  <= be;
    d_i   <= d;
    cmd_i <= BIUCMD_READWAY;
    do @(posedge clk_i); while (!cmd_ack_o);
    cmd_i <= BIUCMD_NOP;
    we_i  <= 1'b0;
    @(posedge clk_i);             // idle gap between bursts
  endtask

  task automatic write_line(input logic [31:0] adr, input logic [127:0] line);
    int base;
    base = u_slave.wr_cnt;
    evict_adr_i  <= adr;
    evict_line_i <= line;
    cmd_i        <= BIUCMD_WRITEWAY;
    do @(posedge clk_i); while (!cmd_ack_o);
    cmd_i <= BIUCMD_NOP;
    @(posedge clk_i);
    check(u_slave.wr_cnt - base == 4, "write beat count");
    for (int i = 0; i < 4; i++)
      check(u_slave.wr_data[base+i] == line[i*32 +: 32] &&
            u_slave.wr_adr[base+i] == adr + 32'(i * 4), $sformatf("write word %0d", i));
  endtask

  task automatic nc_access(input logic [31:0] adr);
    noncacheable_req_i <= 1'b1;
    adr_i <= adr;
    do @(posedge clk_i); while (!stb_ack_i);
    noncacheable_req_i <= 1'b0;
  endtask

  initial
  begin
    rst_ni = 1'b0;
    cmd_i = BIUCMD_NOP;
    noncacheable_req_i = 1'b0;
    flush_i = 1'b0;
    we_i = 1'b0;
    adr_i = '0;
    d_i = '0;
    be_i = '0;
    evict_adr_i = '0;
    evict_line_i = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check(!busy_o && !stb_o && !cmd_ack_o && !noncacheable_ack_o && inflight_cnt_o == 0,
          "outputs after reset");
    read_line(32'h1000_0008, 1'b0, 4'h0, 32'h0);
    read_line(32'h2000_0014, 1'b1, 4'b0110, 32'hdead_beef);
    read_line(32'h3000_003c, 1'b1, 4'b1111, 32'h1234_5678);
    write_line(32'h4000_0020, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210);
    nc_access(32'h5000_0004);     // aligned, incr
    nc_access(32'h5000_0101);     // misaligned, single
    while (inflight_cnt_o != 0) @(posedge clk_i);
    nc_access(32'h6000_0000);
    nc_access(32'h6000_0004);
    flush_i <= 1'b1;              // cancel whatever is still out
    @(posedge clk_i);
    flush_i <= 1'b0;
    while (inflight_cnt_o != 0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    check(inflight_cnt_o == 0, "in-flight count not back to zero");
    $display("%0d checks, %0d errors, %0d acks discarded", n_checks, n_errors, n_suppressed);
    if (n_errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
